// File: build.f
hw/fpu_pkg.sv
hw/arg_change_det.sv
hw/fp_compare.sv
hw/fp_trunc.sv
hw/fp_scaleb.sv
hw/fpu128.sv
tb/fpu128_tb.sv

// File: Bender.yml
package:
  name: fpu128

sources:
  - hw/fpu_pkg.sv
  - hw/arg_change_det.sv
  - hw/fp_compare.sv
  - hw/fp_trunc.sv
  - hw/fp_scaleb.sv
  - hw/fpu128.sv
  - target: simulation
    files:
      - tb/fpu128_tb.sv

// File: tb/fpu128_tb.sv
// ========================================
// Testbench for the binary128 FPU
// Applies a table of operations and checks
// each result and the timing of done
// ========================================
`default_nettype none

module fpu128_tb import fpu_pkg::*; ();

	localparam int MAX_ROWS = 40;
	localparam int WAIT_LIMIT = 20;
	localparam int IDLE_HOLD = 4;

	// Values built by hand from sign, biased exponent and leading fraction bits
	localparam fp_t P_ZERO = {16'h0000, 112'h0};
	localparam fp_t N_ZERO = {16'h8000, 112'h0};
	localparam fp_t P_ONE = {16'h3fff, 112'h0};
	localparam fp_t N_ONE = {16'hbfff, 112'h0};
	localparam fp_t P_TWO = {16'h4000, 112'h0};
	localparam fp_t P_1P5 = {16'h3fff, 4'h8, 108'h0};
	localparam fp_t N_1P5 = {16'hbfff, 4'h8, 108'h0};
	localparam fp_t P_2P5 = {16'h4000, 4'h4, 108'h0};
	localparam fp_t N_2P5 = {16'hc000, 4'h4, 108'h0};
	localparam fp_t P_2P75 = {16'h4000, 4'h6, 108'h0};
	localparam fp_t N_HALF = {16'hbffe, 112'h0};
	localparam fp_t P_2E120 = {16'h4077, 112'h0};
	localparam fp_t P_INF = {16'h7fff, 112'h0};
	localparam fp_t N_INF = {16'hffff, 112'h0};
	localparam fp_t Q_NAN = {16'h7fff, 4'h8, 108'h0};
	localparam fp_t N_SUB = {16'h8000, 108'h0, 4'h1};

	typedef struct packed {
		logic idle;
		opcode_t op;
		func_t fn;
		fp_t a;
		fp_t b;
		fp_t exp_o;
	} row_t;

	logic clk;
	logic rst;
	logic idle;
	opcode_t opcode;
	func_t func;
	fp_t a;
	fp_t b;
	fp_t o;
	logic done;

	row_t rows [MAX_ROWS];
	int n_rows;
	// State of the row in flight
	logic changed;
	logic cur_idle;
	int cur_lat;

	fpu128 fpu128_i (
		.clk(clk),
		.rst(rst),
		.idle(idle),
		.opcode(opcode),
		.func(func),
		.a(a),
		.b(b),
		.o(o),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Checks
	// ========================================
	task automatic report_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_fp(input string name, input fp_t exp_v, input fp_t act_v);
		if (act_v !== exp_v) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			$display("mismatch at %0t: %s expected %b actual %b", $time, name, exp_v, act_v);
			report_failure();
		end
	endtask

	// Cycle c counts from the cycle the row was driven, done waits for a counter of lat
	function automatic logic expect_done(input logic r_idle, input logic r_chg, input int lat,
			input int c);
		if (r_idle) return 1'b0;
		if (!r_chg) return 1'b1;
		return c >= lat + 1;
	endfunction

	// Scale amount sits in the low half word of b
	function automatic fp_t scale_by(input int n);
		return fp_t'({112'h0, n[15:0]});
	endfunction

	// ========================================
	// Stimulus
	// ========================================
	task automatic add_row(input logic r_idle, input opcode_t r_op, input func_t r_fn,
			input fp_t r_a, input fp_t r_b, input fp_t r_o);
		rows[n_rows] = {r_idle, r_op, r_fn, r_a, r_b, r_o};
		n_rows++;
	endtask

	task automatic apply(input logic r_idle, input opcode_t r_op, input func_t r_fn,
			input fp_t r_a, input fp_t r_b);
		@(posedge clk);
		// Compared with the operands still on the bus from the last cycle
		changed = (r_a != a) || (r_b != b);
		cur_idle = r_idle;
		cur_lat = 0;
		if (r_op == OP_FLT && r_fn == FN_FTRUNC) cur_lat = LAT_TRUNC;
		if (r_op == OP_FLT && r_fn == FN_FSCALEB) cur_lat = LAT_SCALEB;
		idle <= r_idle;
		opcode <= r_op;
		func <= r_fn;
		a <= r_a;
		b <= r_b;
	endtask

	// Checks done every cycle until it rises, or holds an idle row for a while
	task automatic await_result(input fp_t exp_o);
		int c;
		logic fin;
		c = 0;
		fin = 1'b0;
		while (!fin) begin
			@(negedge clk);
			check_bit("done", expect_done(cur_idle, changed, cur_lat, c), done);
			fin = done || (cur_idle && c >= IDLE_HOLD);
			c++;
			if (!fin && c > WAIT_LIMIT) begin
				$display("Error at %0t: done never rose", $time);
				report_failure();
			end
		end
		check_fp("o", exp_o, o);
	endtask

	task automatic build_table();
		add_row(1'b0, OP_FLT, FN_FABS, N_2P5, P_ONE, P_2P5);
		add_row(1'b0, OP_FLT, FN_FABS, N_INF, P_ONE, P_INF);
		add_row(1'b0, OP_FLT, FN_FNEG, P_ONE, P_ONE, N_ONE);
		add_row(1'b0, OP_FLT, FN_FNEG, Q_NAN, P_ONE, {16'hffff, 4'h8, 108'h0});
		add_row(1'b0, OP_FLT, FN_ISNAN, Q_NAN, P_ONE, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_ISNAN, P_INF, P_ONE, fp_t'(128'h0));
		add_row(1'b0, OP_FLT, FN_FINITE, P_INF, P_ONE, fp_t'(128'h0));
		add_row(1'b0, OP_FLT, FN_FINITE, N_2P5, P_ONE, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_SGNJ, N_2P5, P_ONE, N_ONE);
		add_row(1'b0, OP_FLT, FN_SGNJN, N_2P5, P_ONE, P_ONE);
		add_row(1'b0, OP_FLT, FN_SGNJX, N_2P5, N_INF, P_INF);
		// Compare word reads unord, le, lt, eq from the top down
		add_row(1'b0, OP_FLT, FN_FSEQ, P_ONE, P_TWO, fp_t'(128'h0));
		add_row(1'b0, OP_FLT, FN_FSNE, P_ONE, P_TWO, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_FSLT, P_ONE, P_TWO, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_FSLE, P_ONE, P_TWO, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_FCMP, P_ONE, P_TWO, fp_t'(128'h6));
		add_row(1'b0, OP_FLT, FN_FSEQ, N_ZERO, P_ZERO, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_FSLT, N_ZERO, P_ZERO, fp_t'(128'h0));
		add_row(1'b0, OP_FLT, FN_FCMP, N_ZERO, P_ZERO, fp_t'(128'h5));
		add_row(1'b0, OP_FLT, FN_FSNE, Q_NAN, P_ONE, fp_t'(128'h1));
		add_row(1'b0, OP_FLT, FN_FSLE, Q_NAN, P_ONE, fp_t'(128'h0));
		add_row(1'b0, OP_FLT, FN_FCMP, Q_NAN, P_ONE, fp_t'(128'h8));
		add_row(1'b0, OP_FLT, FN_FCMP, P_TWO, P_ONE, fp_t'(128'h0));
		// Multi-cycle rows always bring a fresh operand pair
		add_row(1'b0, OP_FLT, FN_FTRUNC, P_2P75, P_ONE, P_TWO);
		add_row(1'b0, OP_FLT, FN_FTRUNC, N_HALF, P_ONE, N_ZERO);
		add_row(1'b0, OP_FLT, FN_FTRUNC, P_2E120, P_ONE, P_2E120);
		add_row(1'b0, OP_FLT, FN_FSCALEB, P_1P5, scale_by(3), {16'h4002, 4'h8, 108'h0});
		add_row(1'b0, OP_FLT, FN_FSCALEB, P_ONE, scale_by(-20000), P_ZERO);
		add_row(1'b0, OP_FLT, FN_FSCALEB, N_ONE, scale_by(20000), N_INF);
		add_row(1'b0, OP_FLT, FN_FSCALEB, N_SUB, scale_by(3), N_ZERO);
		add_row(1'b1, OP_FLT, FN_FABS, N_2P5, P_ONE, P_2P5);
		add_row(1'b0, OP_ALU, FN_FABS, P_ONE, P_ONE, P_ZERO);
	endtask

	// Operands move again while a scaleb is still in flight
	task automatic restart_before_done();
		apply(1'b0, OP_FLT, FN_FSCALEB, P_ONE, scale_by(5));
		await_result({16'h4004, 112'h0});
		apply(1'b0, OP_FLT, FN_FSCALEB, P_1P5, scale_by(1));
		@(negedge clk);
		check_bit("done", 1'b0, done);
		apply(1'b0, OP_FLT, FN_FSCALEB, N_1P5, scale_by(-2));
		await_result({16'hbffd, 4'h8, 108'h0});
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int gap;
		void'($urandom(70));
		rst = 1'b1;
		// Idle is low in reset, so only the reset can keep done low here
		idle = 1'b0;
		opcode = OP_NOP;
		func = FN_FABS;
		a = '0;
		b = '0;
		n_rows = 0;
		changed = 1'b0;
		cur_idle = 1'b1;
		cur_lat = 0;
		build_table();
		@(posedge clk);
		@(negedge clk);
		check_bit("done", 1'b0, done);
		@(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < n_rows; r++) begin
			gap = $urandom % 4;
			repeat (gap) begin
				@(posedge clk);
				idle <= 1'b1;
			end
			apply(rows[r].idle, rows[r].op, rows[r].fn, rows[r].a, rows[r].b);
			await_result(rows[r].exp_o);
		end
		restart_before_done();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/fpu128.sv
// ========================================
// Binary128 floating-point execution unit
// Sign ops, compares, truncate and scaleb
// with a latency counter for done
// ========================================
`default_nettype none

module fpu128 import fpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic idle,
	input opcode_t opcode,
	input func_t func,
	input fp_t a,
	input fp_t b,
	output fp_t o,
	output logic done
);

	logic cd;
	logic [CNT_WID-1:0] cnt;
	cmp_t cmp;
	fp_t trunc_o;
	fp_t scaleb_o;
	logic nan_a;
	logic finite_a;

	// ========================================
	// Unit instances
	// ========================================
	// A new operand pair restarts the latency count
	arg_change_det #(
		.WID(2 * FP_WID)
	) u_arg_cd (
		.clk(clk),
		.rst(rst),
		.i({a, b}),
		.cd(cd)
	);

	fp_compare u_cmp (
		.a(a),
		.b(b),
		.cmp(cmp)
	);

	fp_trunc u_trunc (
		.clk(clk),
		.rst(rst),
		.a(a),
		.o(trunc_o)
	);

	fp_scaleb u_scaleb (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.o(scaleb_o)
	);

	// ========================================
	// Latency counter
	// ========================================
	// Counts cycles since the last operand change and sticks at its top
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (cd) begin
			cnt <= '0;
		end else if (cnt != '1) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Done is withheld in reset, while idle and in a change cycle
	always_comb begin
		done = 1'b0;
		if (!rst && !idle && !cd) begin
			if (opcode == OP_FLT) begin
				case (func)
					FN_FTRUNC: done = cnt >= CNT_WID'(LAT_TRUNC);
					FN_FSCALEB: done = cnt >= CNT_WID'(LAT_SCALEB);
					default: done = 1'b1;
				endcase
			end else begin
				// Foreign opcodes finish at once with a zero result
				done = 1'b1;
			end
		end
	end

	// ========================================
	// Result multiplexer
	// ========================================
	assign nan_a = (&a.exp) && (|a.frac);
	assign finite_a = !(&a.exp);

	always_comb begin
		o = '0;
		if (opcode == OP_FLT) begin
			case (func)
				FN_FABS: o = {1'b0, a.exp, a.frac};
				FN_FNEG: o = {~a.sign, a.exp, a.frac};
				FN_ISNAN: o = fp_t'(FP_WID'(nan_a));
				FN_FINITE: o = fp_t'(FP_WID'(finite_a));
				// Sign injection keeps the magnitude of b
				FN_SGNJ: o = {a.sign, b.exp, b.frac};
				FN_SGNJN: o = {~a.sign, b.exp, b.frac};
				FN_SGNJX: o = {a.sign ^ b.sign, b.exp, b.frac};
				// Predicate compares return a single bit
				FN_FSEQ: o = fp_t'(FP_WID'(cmp.eq));
				FN_FSNE: o = fp_t'(FP_WID'(!cmp.eq));
				FN_FSLT: o = fp_t'(FP_WID'(cmp.lt));
				FN_FSLE: o = fp_t'(FP_WID'(cmp.le));
				FN_FCMP: o = fp_t'(FP_WID'(cmp));
				FN_FTRUNC: o = trunc_o;
				FN_FSCALEB: o = scaleb_o;
				default: o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/fp_scaleb.sv
// ========================================
// Binary128 scale by a power of two
// Two stages, exponent sum then result
// ========================================
`default_nettype none

module fp_scaleb import fpu_pkg::*; (
	input logic clk,
	input logic rst,
	input fp_t a,
	input fp_t b,
	output fp_t o
);

	// Two extra bits hold the sign and the carry of the sum
	localparam int SUM_WID = EXP_WID + 2;
	localparam logic [SUM_WID-2:0] EXP_MAX = {1'b0, {EXP_WID{1'b1}}};

	typedef enum logic [1:0] {
		CL_NORM,
		CL_ZERO,
		CL_SUB,
		CL_SPEC
	} cls_t;

	// Scale factor is the low half word of b read as two's complement
	logic signed [15:0] n;
	logic signed [SUM_WID-1:0] sum;
	cls_t cls;

	fp_t s1_a;
	logic signed [SUM_WID-1:0] s1_sum;
	cls_t s1_cls;
	fp_t res;

	// ========================================
	// Stage 1
	// ========================================
	assign n = b.frac[15:0];
	assign sum = $signed({{(SUM_WID-EXP_WID){1'b0}}, a.exp}) + {{(SUM_WID-16){n[15]}}, n};

	always_comb begin
		if (&a.exp) begin
			cls = CL_SPEC;
		end else if (a.exp != '0) begin
			cls = CL_NORM;
		end else if (a.frac == '0) begin
			cls = CL_ZERO;
		end else begin
			cls = CL_SUB;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_a <= '0;
			s1_sum <= '0;
			s1_cls <= CL_ZERO;
		end else begin
			s1_a <= a;
			s1_sum <= sum;
			s1_cls <= cls;
		end
	end

	// ========================================
	// Stage 2
	// ========================================
	always_comb begin
		res = s1_a;
		if (s1_cls == CL_ZERO || s1_cls == CL_SPEC) begin
			res = s1_a;
		end else if (s1_cls == CL_SUB || s1_sum[SUM_WID-1] || s1_sum == '0) begin
			// Subnormals are flushed, underflow also gives a signed zero
			res.exp = '0;
			res.frac = '0;
		end else if (s1_sum[SUM_WID-2:0] >= EXP_MAX) begin
			// Overflow saturates to infinity
			res.exp = '1;
			res.frac = '0;
		end else begin
			res.exp = s1_sum[EXP_WID-1:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o <= '0;
		end else begin
			o <= res;
		end
	end

endmodule

`default_nettype wire

// File: hw/fp_trunc.sv
// ========================================
// Binary128 truncate toward zero
// One register stage
// ========================================
`default_nettype none

module fp_trunc import fpu_pkg::*; (
	input logic clk,
	input logic rst,
	input fp_t a,
	output fp_t o
);

	// Unbiased exponent, meaningful only when a is at least one
	logic [EXP_WID-1:0] unb;
	// Number of fraction bits below the binary point
	logic [EXP_WID-1:0] clr;
	logic [FRAC_WID-1:0] mask;
	fp_t res;

	assign unb = a.exp - EXP_WID'(EXP_BIAS);
	assign clr = EXP_WID'(FRAC_WID) - unb;
	// Keeps the integer part of the fraction, clr is 1 to 112 here
	assign mask = {FRAC_WID{1'b1}} << clr;

	always_comb begin
		res = a;
		if (a.exp < EXP_WID'(EXP_BIAS)) begin
			// Magnitude below one truncates to a signed zero
			res.exp = '0;
			res.frac = '0;
		end else if (a.exp >= EXP_WID'(EXP_BIAS + FRAC_WID)) begin
			// Already an integer, or infinity or NaN
			res = a;
		end else begin
			res.frac = a.frac & mask;
		end
	end

	// ========================================
	// Output register
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o <= '0;
		end else begin
			o <= res;
		end
	end

endmodule

`default_nettype wire

// File: hw/fp_compare.sv
// ========================================
// Binary128 compare
// Builds the eq, lt, le, unord word
// ========================================
`default_nettype none

module fp_compare import fpu_pkg::*; (
	input fp_t a,
	input fp_t b,
	output cmp_t cmp
);

	logic nan_a;
	logic nan_b;
	logic zero_a;
	logic zero_b;
	logic [EXP_WID+FRAC_WID-1:0] mag_a;
	logic [EXP_WID+FRAC_WID-1:0] mag_b;
	logic mag_lt;
	logic mag_eq;
	logic ord_lt;
	logic ord_eq;

	// NaN has an all ones exponent and a nonzero fraction
	assign nan_a = (&a.exp) && (|a.frac);
	assign nan_b = (&b.exp) && (|b.frac);
	assign zero_a = (a.exp == '0) && (a.frac == '0);
	assign zero_b = (b.exp == '0) && (b.frac == '0);

	// Exponent over fraction orders the magnitude as a plain integer
	assign mag_a = {a.exp, a.frac};
	assign mag_b = {b.exp, b.frac};
	assign mag_lt = mag_a < mag_b;
	assign mag_eq = mag_a == mag_b;

	// Both zeros are equal whatever their signs
	assign ord_eq = (zero_a && zero_b) || (mag_eq && (a.sign == b.sign));

	always_comb begin
		if (zero_a && zero_b) begin
			ord_lt = 1'b0;
		end else if (a.sign != b.sign) begin
			// A negative a is below a positive b
			ord_lt = a.sign;
		end else if (a.sign) begin
			// Negative values reverse the magnitude order
			ord_lt = !mag_lt && !mag_eq;
		end else begin
			ord_lt = mag_lt;
		end
	end

	// Any NaN leaves the pair unordered and clears the rest
	assign cmp.unord = nan_a || nan_b;
	assign cmp.eq = !cmp.unord && ord_eq;
	assign cmp.lt = !cmp.unord && ord_lt;
	assign cmp.le = !cmp.unord && (ord_lt || ord_eq);

endmodule

`default_nettype wire

// File: hw/arg_change_det.sv
// ========================================
// Operand change detector
// Flags any difference from last cycle
// ========================================
`default_nettype none

module arg_change_det #(
	parameter int WID = 256
) (
	input logic clk,
	input logic rst,
	input logic [WID-1:0] i,
	output logic cd
);

	// Copy of the input as it was one cycle ago
	logic [WID-1:0] prev;

	// Cleared on reset so that a first nonzero pair is seen as new
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prev <= '0;
		end else begin
			prev <= i;
		end
	end

	// High for the whole cycle in which the input moved
	assign cd = (i != prev);

endmodule

`default_nettype wire

// File: hw/fpu_pkg.sv
// ========================================
// Binary128 FPU shared definitions
// Format fields, opcode and function codes,
// compare word and unit latencies
// ========================================
`default_nettype none

package fpu_pkg;

	// ========================================
	// Binary128 format
	// ========================================
	localparam int FP_WID = 128;
	localparam int EXP_WID = 15;
	localparam int FRAC_WID = 112;
	localparam int EXP_BIAS = 16383;

	// Sign sits in the top bit, the fraction in the low bits
	typedef struct packed {
		logic sign;
		logic [EXP_WID-1:0] exp;
		logic [FRAC_WID-1:0] frac;
	} fp_t;

	// ========================================
	// Instruction fields
	// ========================================
	// Only OP_FLT belongs to this unit, the rest go to other units
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_ALU = 7'h04,
		OP_MEM = 7'h10,
		OP_FLT = 7'h2c
	} opcode_t;

	typedef enum logic [4:0] {
		FN_FABS = 5'h00,
		FN_FNEG = 5'h01,
		FN_ISNAN = 5'h02,
		FN_FINITE = 5'h03,
		FN_SGNJ = 5'h04,
		FN_SGNJN = 5'h05,
		FN_SGNJX = 5'h06,
		FN_FSEQ = 5'h08,
		FN_FSNE = 5'h09,
		FN_FSLT = 5'h0a,
		FN_FSLE = 5'h0b,
		FN_FCMP = 5'h0c,
		FN_FTRUNC = 5'h10,
		FN_FSCALEB = 5'h11
	} func_t;

	// Compare word, eq lands in bit 0
	typedef struct packed {
		logic unord;
		logic le;
		logic lt;
		logic eq;
	} cmp_t;

	// Cycles from the counter restart until the result is ready
	localparam int LAT_TRUNC = 1;
	localparam int LAT_SCALEB = 2;
	localparam int CNT_WID = 4;

endpackage

`default_nettype wire
